//--- verilog.f
verilog/ifu_pkg.sv
verilog/ifu_ctl_if.sv
verilog/ifu_redirect.sv
verilog/ifu_pc.sv
verilog/ifu_bus.sv
verilog/ifu_top.sv
sim/ifu_asserts.sv
sim/ifu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fetch unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module ifu_tb -o ifu_sim \
    && ./obj_dir/ifu_sim | tee /dev/stderr | grep -q "Finished with no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- sim/ifu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_tb
    import ifu_pkg::*;
();

    // instruction word returned for an address is its low half xor this key
    localparam logic [31:0] DATA_KEY = 32'h5A3C_96E1;

    logic            clk;
    logic            arst_n_i;
    logic            stall_i;
    logic            jal_i;
    logic            jalr_i;
    logic            branch_i;
    logic            trap_i;
    logic [XLEN-1:0] alu_res_i;
    logic [XLEN-1:0] ex_pc_i;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] rs1_data_i;
    logic [XLEN-1:0] mtvec_i;
    logic            ar_valid_o;
    logic            ar_ready_i;
    logic [XLEN-1:0] ar_addr_o;
    logic            r_valid_i;
    logic            r_ready_o;
    logic [XLEN-1:0] r_data_i;
    logic [ILEN-1:0] inst_o;
    logic [XLEN-1:0] pc_o;
    logic            inst_valid_o;

    logic [15:0]     lfsr_q;
    logic            random_on;
    logic            timed_out;
    int              errors;
    int              checks;
    int              emitted;
    int              n_jump;
    int              n_jalr;
    int              n_trap;
    int              n_stall_drop;

    // reference model and responder state
    logic [XLEN-1:0] exp_pc;
    logic [XLEN-1:0] exp_out_pc;
    logic            exp_valid;
    logic [XLEN-1:0] beat_addr;
    int              ar_wait;
    int              r_wait;
    logic            r_pending;

    ifu_top i_ifu_top (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .stall_i      (stall_i),
        .jal_i        (jal_i),
        .jalr_i       (jalr_i),
        .branch_i     (branch_i),
        .trap_i       (trap_i),
        .alu_res_i    (alu_res_i),
        .ex_pc_i      (ex_pc_i),
        .imm_i        (imm_i),
        .rs1_data_i   (rs1_data_i),
        .mtvec_i      (mtvec_i),
        .ar_valid_o   (ar_valid_o),
        .ar_ready_i   (ar_ready_i),
        .ar_addr_o    (ar_addr_o),
        .r_valid_i    (r_valid_i),
        .r_ready_o    (r_ready_o),
        .r_data_i     (r_data_i),
        .inst_o       (inst_o),
        .pc_o         (pc_o),
        .inst_valid_o (inst_valid_o)
    );

    always #5 clk = ~clk;

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] next_rand(input int nbits);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < nbits; k++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [ILEN-1:0] data_of(input logic [XLEN-1:0] addr);
        return addr[31:0] ^ DATA_KEY;
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] exp_v,
                               input logic [XLEN-1:0] act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp_v, act_v);
        end
    endtask

    task automatic note_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("timeout while waiting for %s", what);
    endtask

    task automatic wait_emitted(input int target, input int limit);
        for (int i = 0; i < limit && emitted < target && !timed_out; i++) begin
            @(posedge clk);
        end
        if (emitted < target && !timed_out) begin
            note_timeout("fetched instructions");
        end
    endtask

    // model, checks and responder, all on the rising edge
    always @(posedge clk) begin
        logic [XLEN-1:0] target;
        logic            redir;
        logic            fire;
        logic            adv;
        if (arst_n_i) begin
            check_value("inst_valid", exp_valid, inst_valid_o);
            if (exp_valid && inst_valid_o) begin
                check_value("pc_o", exp_out_pc, pc_o);
                check_value("inst_o", data_of(exp_out_pc), inst_o);
                emitted++;
            end else if (!exp_valid) begin
                check_value("idle pc_o", '0, pc_o);
                check_value("idle inst_o", '0, inst_o);
            end

            redir  = 1'b1;
            target = '0;
            if (jal_i || (branch_i && alu_res_i == '0)) begin
                target = ex_pc_i + imm_i;
                n_jump++;
            end else if (jalr_i) begin
                target = (rs1_data_i + imm_i) & ~64'd1;
                n_jalr++;
            end else if (trap_i) begin
                target = mtvec_i;
                n_trap++;
            end else begin
                redir = 1'b0;
            end

            fire = r_valid_i && r_ready_o;
            adv  = fire && (beat_addr == exp_pc) && !stall_i && !redir;
            if (fire && stall_i && (beat_addr == exp_pc) && !redir) begin
                n_stall_drop++;
            end
            exp_valid  = adv;
            exp_out_pc = exp_pc;
            if (redir) begin
                exp_pc = target;
            end else if (adv) begin
                exp_pc = exp_pc + 64'd4;
            end

            // address channel
            if (ar_valid_o && ar_ready_i) begin
                beat_addr = ar_addr_o;
                check_value("fetch size", FETCH_SIZE, i_ifu_top.i_ifu_bus.ar_size);
                ar_wait    = next_rand(2);
                ar_ready_i <= (ar_wait == 0);
                r_wait     = next_rand(2);
                r_pending  = 1'b1;
                r_data_i   <= {32'd0, data_of(ar_addr_o)};
            end else if (ar_valid_o) begin
                if (ar_wait > 0) begin
                    ar_wait--;
                end
                ar_ready_i <= (ar_wait == 0);
            end

            // data channel
            if (fire) begin
                r_valid_i <= 1'b0;
                r_pending = 1'b0;
            end else if (r_pending) begin
                if (r_wait > 0) begin
                    r_wait--;
                end else begin
                    r_valid_i <= 1'b1;
                end
            end

            if (random_on) begin
                stall_i <= (next_rand(3) == 0);
                if (next_rand(4) == 0) begin
                    jal_i      <= next_rand(1);
                    jalr_i     <= next_rand(1);
                    branch_i   <= next_rand(1);
                    trap_i     <= next_rand(1);
                    alu_res_i  <= next_rand(1) ? 64'd0 : ({32'd0, next_rand(16)} | 64'd1);
                    ex_pc_i    <= RESET_PC + {next_rand(16), 2'b00};
                    imm_i      <= {next_rand(12), 2'b00};
                    rs1_data_i <= RESET_PC + next_rand(16);
                    mtvec_i    <= RESET_PC + 64'h10_0000 + {next_rand(8), 2'b00};
                end else begin
                    jal_i    <= 1'b0;
                    jalr_i   <= 1'b0;
                    branch_i <= 1'b0;
                    trap_i   <= 1'b0;
                end
            end
        end
    end

    initial begin
        clk        = 1'b0;
        arst_n_i   = 1'b0;
        stall_i    = 1'b0;
        jal_i      = 1'b0;
        jalr_i     = 1'b0;
        branch_i   = 1'b0;
        trap_i     = 1'b0;
        alu_res_i  = '0;
        ex_pc_i    = '0;
        imm_i      = '0;
        rs1_data_i = '0;
        mtvec_i    = '0;
        ar_ready_i = 1'b0;
        r_valid_i  = 1'b0;
        r_data_i   = '0;
        lfsr_q     = 16'd31529;
        random_on  = 1'b0;
        timed_out  = 1'b0;
        errors     = 0;
        checks     = 0;
        emitted    = 0;
        n_jump     = 0;
        n_jalr     = 0;
        n_trap     = 0;
        n_stall_drop = 0;
        exp_pc     = RESET_PC;
        exp_out_pc = '0;
        exp_valid  = 1'b0;
        beat_addr  = '0;
        ar_wait    = 0;
        r_wait     = 0;
        r_pending  = 1'b0;

        repeat (8) begin
            @(posedge clk);
            check_value("reset ar_valid", 64'd0, ar_valid_o);
            check_value("reset inst_valid", 64'd0, inst_valid_o);
        end
        arst_n_i <= 1'b1;

        // first request carries the reset pc
        for (int i = 0; i < 20 && !ar_valid_o; i++) begin
            @(posedge clk);
        end
        if (!ar_valid_o) begin
            note_timeout("first address request");
        end else begin
            check_value("first ar_addr", RESET_PC, ar_addr_o);
        end

        // straight line fetch, then random redirects and stalls
        wait_emitted(20, 400);
        random_on <= 1'b1;
        wait_emitted(320, 20000);

        if (!timed_out) begin
            if (n_jump == 0 || n_jalr == 0 || n_trap == 0) begin
                errors++;
                $display("not every redirect cause was exercised");
            end
            if (n_stall_drop == 0) begin
                errors++;
                $display("no beat was dropped by a stall");
            end
        end

        $display("checks %0d, errors %0d, instructions %0d", checks, errors, emitted);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/ifu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_asserts
    import ifu_pkg::*;
(
    input wire logic            clk,
    input wire logic            arst_n_i,
    input wire logic            ar_valid,
    input wire logic            ar_ready,
    input wire logic [XLEN-1:0] ar_addr,
    input wire logic            r_ready,
    input wire logic            stale_beat,
    input wire logic            inst_valid,
    input wire logic            advance
);

    // held request keeps its address
    a_addr_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
        else $error("ar_addr changed while waiting for ar_ready");

    // one read outstanding
    a_one_channel: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(ar_valid && r_ready))
        else $error("ar_valid and r_ready high together");

    // a dropped beat never moves the pc on from its address
    a_stale_dropped: assert property (@(posedge clk) disable iff (!arst_n_i)
        stale_beat |=> ar_valid && (ar_addr != $past(ar_addr) + PC_STEP))
        else $error("stale beat advanced the fetch pc");

    // single cycle pulse unless the next beat advanced
    a_inst_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        inst_valid |=> !inst_valid || $past(advance))
        else $error("inst_valid held without a new beat");

endmodule

bind ifu_bus ifu_asserts i_bus_asserts (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .ar_valid   (ar_valid_o),
    .ar_ready   (ar_ready_i),
    .ar_addr    (ar_addr_o),
    .r_ready    (r_ready_o),
    .stale_beat (stale_beat),
    .inst_valid (1'b0),
    .advance    (1'b0)
);

bind ifu_pc ifu_asserts i_pc_asserts (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .ar_valid   (1'b0),
    .ar_ready   (1'b0),
    .ar_addr    ('0),
    .r_ready    (1'b0),
    .stale_beat (1'b0),
    .inst_valid (inst_valid_o),
    .advance    (advance)
);

`default_nettype wire

//--- verilog/ifu_top.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_top
    import ifu_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            arst_n_i,
    input  wire logic            stall_i,

    // redirect sources from the execute/memory stage
    input  wire logic            jal_i,
    input  wire logic            jalr_i,
    input  wire logic            branch_i,
    input  wire logic            trap_i,
    input  wire logic [XLEN-1:0] alu_res_i,
    input  wire logic [XLEN-1:0] ex_pc_i,
    input  wire logic [XLEN-1:0] imm_i,
    input  wire logic [XLEN-1:0] rs1_data_i,
    input  wire logic [XLEN-1:0] mtvec_i,

    // read address channel
    output logic                 ar_valid_o,
    input  wire logic            ar_ready_i,
    output logic [XLEN-1:0]      ar_addr_o,

    // read data channel
    input  wire logic            r_valid_i,
    output logic                 r_ready_o,
    input  wire logic [XLEN-1:0] r_data_i,

    // fetched instruction towards decode
    output logic [ILEN-1:0]      inst_o,
    output logic [XLEN-1:0]      pc_o,
    output logic                 inst_valid_o
);

    redirect_cause_t redirect;
    logic [XLEN-1:0] target;

    ifu_ctl_if i_ctl_if ();

    ifu_redirect i_ifu_redirect (
        .jal_i      (jal_i),
        .jalr_i     (jalr_i),
        .branch_i   (branch_i),
        .trap_i     (trap_i),
        .alu_res_i  (alu_res_i),
        .ex_pc_i    (ex_pc_i),
        .imm_i      (imm_i),
        .rs1_data_i (rs1_data_i),
        .mtvec_i    (mtvec_i),
        .redirect_o (redirect),
        .target_o   (target)
    );

    ifu_pc i_ifu_pc (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .stall_i      (stall_i),
        .redirect_i   (redirect),
        .target_i     (target),
        .ctl          (i_ctl_if.pc_side),
        .r_data_i     (r_data_i),
        .inst_o       (inst_o),
        .pc_o         (pc_o),
        .inst_valid_o (inst_valid_o)
    );

    ifu_bus i_ifu_bus (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .ctl        (i_ctl_if.bus_side),
        .ar_valid_o (ar_valid_o),
        .ar_ready_i (ar_ready_i),
        .ar_addr_o  (ar_addr_o),
        .r_valid_i  (r_valid_i),
        .r_ready_o  (r_ready_o)
    );

endmodule

`default_nettype wire

//--- verilog/ifu_bus.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_bus
    import ifu_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            arst_n_i,
    ifu_ctl_if.bus_side          ctl,
    output logic                 ar_valid_o,
    input  wire logic            ar_ready_i,
    output logic [XLEN-1:0]      ar_addr_o,
    input  wire logic            r_valid_i,
    output logic                 r_ready_o
);

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_ADDR = 2'd1,
        ST_DATA = 2'd2
    } state_t;

    state_t          state_q;
    logic            fresh_q;
    logic [XLEN-1:0] req_addr_q;
    logic [1:0]      flush_cnt_q;
    logic            ar_fire;
    logic            r_fire;
    logic            in_flight;
    logic            stale_beat;
    logic [7:0]      ar_size;

    // size code of every fetch, seen by the bound checks
    assign ar_size = FETCH_SIZE;

    assign ar_valid_o = (state_q == ST_ADDR);
    assign r_ready_o  = (state_q == ST_DATA);

    assign ar_fire = ar_valid_o && ar_ready_i;
    assign r_fire  = r_valid_i && r_ready_o;

    // first address cycle follows the live pc so an update on the
    // previous edge is already part of the request
    assign ar_addr_o = fresh_q ? ctl.pc : req_addr_q;

    assign ctl.accept      = r_fire;
    assign ctl.accept_addr = req_addr_q;

    assign in_flight = (state_q == ST_ADDR) || (state_q == ST_DATA);

    // beat whose address the pc has left behind
    assign stale_beat = r_fire && ((flush_cnt_q != 2'd0) || ctl.flush);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
            fresh_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    state_q <= ST_ADDR;
                    fresh_q <= 1'b1;
                end
                ST_ADDR: begin
                    fresh_q <= 1'b0;
                    if (ar_fire) begin
                        state_q <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    // next request goes out on the same edge
                    if (r_fire) begin
                        state_q <= ST_ADDR;
                        fresh_q <= 1'b1;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                    fresh_q <= 1'b0;
                end
            endcase
        end
    end

    // request address is taken from the pc in the first address cycle
    always_ff @(posedge clk) begin
        if (fresh_q) begin
            req_addr_q <= ctl.pc;
        end
    end

    // redirects seen since the request address was sampled
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            flush_cnt_q <= 2'd0;
        end else if (r_fire) begin
            flush_cnt_q <= 2'd0;
        end else if (in_flight && ctl.flush && (flush_cnt_q != 2'd3)) begin
            flush_cnt_q <= flush_cnt_q + 2'd1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/ifu_pc.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_pc
    import ifu_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            arst_n_i,
    input  wire logic            stall_i,
    input  wire redirect_cause_t redirect_i,
    input  wire logic [XLEN-1:0] target_i,
    ifu_ctl_if.pc_side           ctl,
    input  wire logic [XLEN-1:0] r_data_i,
    output logic [ILEN-1:0]      inst_o,
    output logic [XLEN-1:0]      pc_o,
    output logic                 inst_valid_o
);

    logic [XLEN-1:0] pc_q;
    logic            redirect_hit;
    logic            beat_match;
    logic            advance;

    assign redirect_hit = (redirect_i != REDIR_NONE);

    // beat belongs to the pc still waiting for its instruction
    assign beat_match = ctl.accept && (ctl.accept_addr == pc_q);

    // a stall or a redirect drops the beat, the address gets fetched again
    assign advance = beat_match && !stall_i && !redirect_hit;

    assign ctl.pc    = pc_q;
    assign ctl.flush = redirect_hit;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
        end else if (redirect_hit) begin
            pc_q <= target_i;
        end else if (advance) begin
            pc_q <= pc_q + PC_STEP;
        end
    end

    // one cycle instruction pulse, zeros in between
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            inst_valid_o <= 1'b0;
            inst_o       <= '0;
            pc_o         <= '0;
        end else if (advance) begin
            inst_valid_o <= 1'b1;
            inst_o       <= r_data_i[ILEN-1:0];
            pc_o         <= pc_q;
        end else begin
            inst_valid_o <= 1'b0;
            inst_o       <= '0;
            pc_o         <= '0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/ifu_redirect.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_redirect
    import ifu_pkg::*;
(
    input  wire logic            jal_i,
    input  wire logic            jalr_i,
    input  wire logic            branch_i,
    input  wire logic            trap_i,
    input  wire logic [XLEN-1:0] alu_res_i,
    input  wire logic [XLEN-1:0] ex_pc_i,
    input  wire logic [XLEN-1:0] imm_i,
    input  wire logic [XLEN-1:0] rs1_data_i,
    input  wire logic [XLEN-1:0] mtvec_i,
    output redirect_cause_t      redirect_o,
    output logic [XLEN-1:0]      target_o
);

    logic            branch_taken;
    logic [XLEN-1:0] jump_target;
    logic [XLEN-1:0] jalr_sum;
    logic [XLEN-1:0] jalr_target;

    // branch compare result comes back as zero when taken
    assign branch_taken = branch_i && (alu_res_i == '0);

    // pc relative target for jal and branches
    assign jump_target = ex_pc_i + imm_i;

    // jalr target has bit 0 forced low
    assign jalr_sum    = rs1_data_i + imm_i;
    assign jalr_target = {jalr_sum[XLEN-1:1], 1'b0};

    // jump or branch wins over jalr, jalr wins over trap
    always_comb begin
        redirect_o = REDIR_NONE;
        target_o   = '0;
        if (jal_i || branch_taken) begin
            redirect_o = REDIR_JUMP;
            target_o   = jump_target;
        end else if (jalr_i) begin
            redirect_o = REDIR_JALR;
            target_o   = jalr_target;
        end else if (trap_i) begin
            redirect_o = REDIR_TRAP;
            target_o   = mtvec_i;
        end
    end

endmodule

`default_nettype wire

//--- verilog/ifu_ctl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ifu_ctl_if
    import ifu_pkg::*;
();

    // current fetch pc, owned by the pc holder
    logic [XLEN-1:0] pc;
    // redirect taken at the coming edge
    logic            flush;
    // data beat taken this cycle
    logic            accept;
    // address the taken beat was requested for
    logic [XLEN-1:0] accept_addr;

    modport pc_side (
        output pc,
        output flush,
        input  accept,
        input  accept_addr
    );

    modport bus_side (
        input  pc,
        input  flush,
        output accept,
        output accept_addr
    );

endinterface

`default_nettype wire

//--- verilog/ifu_pkg.sv
`default_nettype none

package ifu_pkg;

    // datapath widths
    localparam int XLEN = 64;
    localparam int ILEN = 32;

    // first fetch address after reset
    localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

    // byte mask code of one fetch, four bytes of a 32-bit instruction
    localparam logic [7:0] FETCH_SIZE = 8'h0F;

    // pc step of a sequential fetch
    localparam logic [XLEN-1:0] PC_STEP = 64'd4;

    // why the pc leaves the sequential path
    typedef enum logic [1:0] {
        REDIR_NONE = 2'd0,
        REDIR_JUMP = 2'd1,
        REDIR_JALR = 2'd2,
        REDIR_TRAP = 2'd3
    } redirect_cause_t;

endpackage

`default_nettype wire
